// ==== cipher_ctrl.f ====
logic/cipher_ctrl_pkg.sv
logic/cipher_round_ctr.sv
logic/key_word_sel.sv
logic/cipher_ctrl_fsm.sv
logic/cipher_ctrl_top.sv
tb/cipher_ctrl_tb.sv

// ==== logic/cipher_ctrl_fsm.sv ====
/*
 * AES cipher control FSM
 * Sequences the rounds, paces S-Box steps and drives the datapath
 * selects and write enables
 */
`timescale 1ns/1ns
`default_nettype none

module cipher_ctrl_fsm import cipher_ctrl_pkg::*; #(
  parameter int SBoxMinCycles = 4
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,

  // Block handshake and command
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  output logic          out_valid_o,
  input  wire logic     out_ready_i,
  input  wire logic     crypt_i,
  input  wire logic     key_clear_i,
  input  wire logic     data_out_clear_i,
  input  wire ciph_op_e op_i,
  input  wire key_len_e key_len_i,

  // Error inputs and alert
  input  wire logic     mux_sel_err_i,
  input  wire logic     sp_enc_err_i,
  input  wire logic     rnd_ctr_err_i,
  input  wire logic     op_err_i,
  input  wire logic     alert_fatal_i,
  output logic          alert_o,

  // Cipher datapath
  output state_sel_e    state_sel_o,
  output logic          state_we_o,
  output add_rk_sel_e   add_rk_sel_o,
  output logic          sub_bytes_en_o,
  input  wire logic     sub_bytes_out_req_i,
  output logic          sub_bytes_out_ack_o,

  // Key expand datapath
  output key_full_sel_e key_full_sel_o,
  output logic          key_full_we_o,
  output key_dec_sel_e  key_dec_sel_o,
  output logic          key_dec_we_o,
  output logic          key_expand_en_o,
  input  wire logic     key_expand_out_req_i,
  output logic          key_expand_out_ack_o,
  output logic          key_expand_clear_o,

  // Round counter and key word decoder
  output logic          rnd_load_o,
  output logic          rnd_step_o,
  input  wire logic     last_regular_i,
  output round_phase_e  phase_o
);

  ctrl_state_e state_d, state_q;
  cyc_ctr_t    cyc_ctr_d, cyc_ctr_q;
  cyc_ctr_t    cyc_ctr_inc;
  logic        cyc_gate;
  logic        advance;
  logic        key_clear_d, key_clear_q;
  logic        data_out_clear_d, data_out_clear_q;
  logic        any_err;
  logic        out_err;

  ////////////////////////////////////////
  // Cycle gate
  ////////////////////////////////////////

  // Saturate so the gate stays open while waiting
  assign cyc_ctr_inc = (cyc_ctr_q == '1) ? cyc_ctr_q : cyc_ctr_q + cyc_ctr_t'(1);
  // A zero minimum leaves the gate open all the time
  assign cyc_gate    = (cyc_ctr_q >= cyc_ctr_t'(SBoxMinCycles));

  assign any_err = mux_sel_err_i | sp_enc_err_i | rnd_ctr_err_i | op_err_i | alert_fatal_i;
  // Errors that must keep the result from being released
  assign out_err = mux_sel_err_i | sp_enc_err_i | op_err_i;

  ////////////////////////////////////////
  // Next state and output decode
  ////////////////////////////////////////

  always_comb begin
    in_ready_o           = 1'b0;
    out_valid_o          = 1'b0;
    alert_o              = 1'b0;

    state_sel_o          = STATE_ROUND;
    state_we_o           = 1'b0;
    add_rk_sel_o         = ADD_RK_ROUND;
    sub_bytes_en_o       = 1'b0;
    sub_bytes_out_ack_o  = 1'b0;

    key_full_sel_o       = KEY_FULL_ROUND;
    key_full_we_o        = 1'b0;
    key_dec_sel_o        = KEY_DEC_EXPAND;
    key_dec_we_o         = 1'b0;
    key_expand_en_o      = 1'b0;
    key_expand_out_ack_o = 1'b0;
    key_expand_clear_o   = 1'b0;

    rnd_load_o           = 1'b0;
    rnd_step_o           = 1'b0;

    state_d              = state_q;
    key_clear_d          = key_clear_q;
    data_out_clear_d     = data_out_clear_q;
    advance              = 1'b0;
    // Gate only counts inside the cipher rounds
    cyc_ctr_d            = '0;

    unique case (state_q)
      IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          if (key_clear_i || data_out_clear_i) begin
            // Clear wins over crypt
            key_clear_d      = key_clear_i;
            data_out_clear_d = data_out_clear_i;
            // Data output clear goes through the state first
            state_d = data_out_clear_i ? CLEAR_S : CLEAR_KD;
          end else if (crypt_i) begin
            // Load input data and full key, restart key expansion
            state_sel_o        = STATE_INIT;
            state_we_o         = 1'b1;
            key_expand_clear_o = 1'b1;
            key_full_sel_o     = (op_i == CIPH_INV) ? KEY_FULL_DEC_INIT : KEY_FULL_ENC_INIT;
            key_full_we_o      = 1'b1;
            rnd_load_o         = 1'b1;
            state_d            = INIT;
          end else begin
            // Handshake without any command
            state_d = ERROR;
          end
        end
      end

      INIT: begin
        add_rk_sel_o = ADD_RK_INIT;
        cyc_ctr_d    = cyc_ctr_inc;
        if (key_len_i != AES_256) begin
          // Wait on KeyExpand for the second round key
          key_expand_en_o = 1'b1;
          advance         = key_expand_out_req_i & cyc_gate;
          if (advance) begin
            key_expand_out_ack_o = 1'b1;
            state_we_o           = 1'b1;
            key_full_we_o        = 1'b1;
            rnd_step_o           = 1'b1;
            cyc_ctr_d            = '0;
            state_d              = ROUND;
          end
        end else begin
          // AES-256 holds two round keys from the start
          state_we_o = 1'b1;
          rnd_step_o = 1'b1;
          cyc_ctr_d  = '0;
          state_d    = ROUND;
        end
      end

      ROUND: begin
        sub_bytes_en_o  = 1'b1;
        key_expand_en_o = 1'b1;
        cyc_ctr_d       = cyc_ctr_inc;
        // Step once SubBytes and KeyExpand both have results
        advance = sub_bytes_out_req_i & key_expand_out_req_i & cyc_gate;
        if (advance) begin
          sub_bytes_out_ack_o  = 1'b1;
          key_expand_out_ack_o = 1'b1;
          state_we_o           = 1'b1;
          key_full_we_o        = 1'b1;
          rnd_step_o           = 1'b1;
          cyc_ctr_d            = '0;
          if (last_regular_i) begin
            state_d = FINISH;
          end
        end
      end

      FINISH: begin
        // Final round skips MixColumns
        add_rk_sel_o   = ADD_RK_FINAL;
        // State is wiped when the result is taken
        state_sel_o    = STATE_CLEAR;
        sub_bytes_en_o = 1'b1;
        cyc_ctr_d      = cyc_ctr_inc;
        advance        = sub_bytes_out_req_i & cyc_gate;
        out_valid_o    = advance & ~out_err;
        if (out_valid_o && out_ready_i) begin
          sub_bytes_out_ack_o = 1'b1;
          state_we_o          = 1'b1;
          cyc_ctr_d           = '0;
          state_d             = IDLE;
        end
      end

      CLEAR_S: begin
        state_sel_o = STATE_CLEAR;
        state_we_o  = 1'b1;
        state_d     = CLEAR_KD;
      end

      CLEAR_KD: begin
        if (key_clear_q) begin
          key_full_sel_o = KEY_FULL_CLEAR;
          key_full_we_o  = 1'b1;
          key_dec_sel_o  = KEY_DEC_CLEAR;
          key_dec_we_o   = 1'b1;
        end
        // Pass the cleared state on to the data output registers
        if (data_out_clear_q) begin
          add_rk_sel_o = ADD_RK_INIT;
        end
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          key_clear_d      = 1'b0;
          data_out_clear_d = 1'b0;
          state_d          = IDLE;
        end
      end

      // Terminal state left only by reset
      ERROR: alert_o = 1'b1;

      default: begin
        alert_o = 1'b1;
        state_d = ERROR;
      end
    endcase

    // Any error input overrides the normal flow
    if (any_err) begin
      state_d = ERROR;
    end
  end

  // Phase for the key word decoder
  always_comb begin
    case (state_q)
      INIT:    phase_o = PH_INIT;
      ROUND:   phase_o = PH_ROUND;
      FINISH:  phase_o = PH_FINISH;
      default: phase_o = PH_OTHER;
    endcase
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= IDLE;
      cyc_ctr_q        <= '0;
      key_clear_q      <= 1'b0;
      data_out_clear_q <= 1'b0;
    end else begin
      state_q          <= state_d;
      cyc_ctr_q        <= cyc_ctr_d;
      key_clear_q      <= key_clear_d;
      data_out_clear_q <= data_out_clear_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cipher_ctrl_pkg.sv ====
/*
 * AES cipher control package
 * Shared enums and vector types for the cipher control unit
 */
`default_nettype none

package cipher_ctrl_pkg;

  // Cipher operation
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Key length, one-hot coded
  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  // Control FSM states
  typedef enum logic [2:0] {
    IDLE, INIT, ROUND, FINISH, CLEAR_S, CLEAR_KD, ERROR
  } ctrl_state_e;

  // Round phase as seen by the key word decoder
  typedef enum logic [1:0] {
    PH_OTHER, PH_INIT, PH_ROUND, PH_FINISH
  } round_phase_e;

  // Datapath mux selects
  typedef enum logic [1:0] {
    STATE_ROUND, STATE_INIT, STATE_CLEAR
  } state_sel_e;

  typedef enum logic [1:0] {
    ADD_RK_INIT, ADD_RK_ROUND, ADD_RK_FINAL
  } add_rk_sel_e;

  typedef enum logic [1:0] {
    KEY_FULL_ENC_INIT, KEY_FULL_DEC_INIT, KEY_FULL_ROUND, KEY_FULL_CLEAR
  } key_full_sel_e;

  typedef enum logic {
    KEY_DEC_EXPAND, KEY_DEC_CLEAR
  } key_dec_sel_e;

  typedef enum logic [1:0] {
    KEY_WORDS_0123, KEY_WORDS_2345, KEY_WORDS_4567, KEY_WORDS_ZERO
  } key_words_sel_e;

  // Mixed round key is used by the equivalent inverse cipher
  typedef enum logic {
    ROUND_KEY_DIRECT, ROUND_KEY_MIXED
  } round_key_sel_e;

  // Round number and round total
  typedef logic [3:0] rnd_ctr_t;

  // S-Box cycle count
  typedef logic [2:0] cyc_ctr_t;

endpackage

`default_nettype wire

// ==== logic/cipher_ctrl_top.sv ====
/*
 * AES cipher control unit
 * Ties the control FSM to the round counter and key word decoder
 */
`timescale 1ns/1ns
`default_nettype none

module cipher_ctrl_top import cipher_ctrl_pkg::*; #(
  parameter int SBoxMinCycles = 4
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,

  // Block handshake and command
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  output logic          out_valid_o,
  input  wire logic     out_ready_i,
  input  wire logic     crypt_i,
  input  wire logic     key_clear_i,
  input  wire logic     data_out_clear_i,
  input  wire ciph_op_e op_i,
  input  wire key_len_e key_len_i,

  // Errors and alert
  input  wire logic     mux_sel_err_i,
  input  wire logic     sp_enc_err_i,
  input  wire logic     rnd_ctr_err_i,
  input  wire logic     op_err_i,
  input  wire logic     alert_fatal_i,
  output logic          alert_o,

  // Cipher datapath
  output state_sel_e    state_sel_o,
  output logic          state_we_o,
  output add_rk_sel_e   add_rk_sel_o,
  output logic          sub_bytes_en_o,
  input  wire logic     sub_bytes_out_req_i,
  output logic          sub_bytes_out_ack_o,

  // Key expand datapath
  output key_full_sel_e key_full_sel_o,
  output logic          key_full_we_o,
  output key_dec_sel_e  key_dec_sel_o,
  output logic          key_dec_we_o,
  output logic          key_expand_en_o,
  input  wire logic     key_expand_out_req_i,
  output logic          key_expand_out_ack_o,
  output logic          key_expand_clear_o,
  output rnd_ctr_t      rnd_ctr_o,
  output key_words_sel_e key_words_sel_o,
  output round_key_sel_e round_key_sel_o
);

  logic         rnd_load;
  logic         rnd_step;
  logic         last_regular;
  round_phase_e phase;

  // Main control FSM
  cipher_ctrl_fsm #(
    .SBoxMinCycles (SBoxMinCycles)
  ) u_fsm (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .in_valid_i           (in_valid_i),
    .in_ready_o           (in_ready_o),
    .out_valid_o          (out_valid_o),
    .out_ready_i          (out_ready_i),
    .crypt_i              (crypt_i),
    .key_clear_i          (key_clear_i),
    .data_out_clear_i     (data_out_clear_i),
    .op_i                 (op_i),
    .key_len_i            (key_len_i),
    .mux_sel_err_i        (mux_sel_err_i),
    .sp_enc_err_i         (sp_enc_err_i),
    .rnd_ctr_err_i        (rnd_ctr_err_i),
    .op_err_i             (op_err_i),
    .alert_fatal_i        (alert_fatal_i),
    .alert_o              (alert_o),
    .state_sel_o          (state_sel_o),
    .state_we_o           (state_we_o),
    .add_rk_sel_o         (add_rk_sel_o),
    .sub_bytes_en_o       (sub_bytes_en_o),
    .sub_bytes_out_req_i  (sub_bytes_out_req_i),
    .sub_bytes_out_ack_o  (sub_bytes_out_ack_o),
    .key_full_sel_o       (key_full_sel_o),
    .key_full_we_o        (key_full_we_o),
    .key_dec_sel_o        (key_dec_sel_o),
    .key_dec_we_o         (key_dec_we_o),
    .key_expand_en_o      (key_expand_en_o),
    .key_expand_out_req_i (key_expand_out_req_i),
    .key_expand_out_ack_o (key_expand_out_ack_o),
    .key_expand_clear_o   (key_expand_clear_o),
    .rnd_load_o           (rnd_load),
    .rnd_step_o           (rnd_step),
    .last_regular_i       (last_regular),
    .phase_o              (phase)
  );

  // Round count per block
  cipher_round_ctr u_round_ctr (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .load_i         (rnd_load),
    .step_i         (rnd_step),
    .key_len_i      (key_len_i),
    .rnd_ctr_o      (rnd_ctr_o),
    .last_regular_o (last_regular)
  );

  // Key word and round key selection
  key_word_sel u_key_word_sel (
    .phase_i         (phase),
    .op_i            (op_i),
    .key_len_i       (key_len_i),
    .key_words_sel_o (key_words_sel_o),
    .round_key_sel_o (round_key_sel_o)
  );

endmodule

`default_nettype wire

// ==== logic/cipher_round_ctr.sv ====
/*
 * AES round counter
 * Loads the round total from the key length, counts rounds
 * and flags the last regular round
 */
`timescale 1ns/1ns
`default_nettype none

module cipher_round_ctr import cipher_ctrl_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,

  // Control from the FSM
  input  wire logic     load_i,
  input  wire logic     step_i,
  input  wire key_len_e key_len_i,

  // Count and last round flag
  output rnd_ctr_t      rnd_ctr_o,
  output logic          last_regular_o
);

  rnd_ctr_t num_rounds_lut;
  rnd_ctr_t num_rounds_q;
  rnd_ctr_t num_rounds_regular;
  rnd_ctr_t rnd_ctr_q;

  // Round total per key length
  always_comb begin
    case (key_len_i)
      AES_128: num_rounds_lut = rnd_ctr_t'(10);
      AES_192: num_rounds_lut = rnd_ctr_t'(12);
      // AES-256 and any stray encoding
      default: num_rounds_lut = rnd_ctr_t'(14);
    endcase
  end

  ////////////////////////////////////////
  // Count registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      num_rounds_q <= '0;
      rnd_ctr_q    <= '0;
    end else if (load_i) begin
      // New block latches the total and restarts the count
      num_rounds_q <= num_rounds_lut;
      rnd_ctr_q    <= '0;
    end else if (step_i) begin
      rnd_ctr_q    <= rnd_ctr_q + rnd_ctr_t'(1);
    end
  end

  // The final round is not a regular round
  assign num_rounds_regular = num_rounds_q - rnd_ctr_t'(1);

  // High throughout the last regular round
  assign last_regular_o = (rnd_ctr_q >= num_rounds_regular);
  assign rnd_ctr_o      = rnd_ctr_q;

endmodule

`default_nettype wire

// ==== logic/key_word_sel.sv ====
/*
 * AES key word decoder
 * Picks key words and the round key form per round phase
 */
`timescale 1ns/1ns
`default_nettype none

module key_word_sel import cipher_ctrl_pkg::*; (
  input  wire round_phase_e phase_i,
  input  wire ciph_op_e     op_i,
  input  wire key_len_e     key_len_i,

  output key_words_sel_e    key_words_sel_o,
  output round_key_sel_e    round_key_sel_o
);

  logic is_fwd;

  assign is_fwd = (op_i == CIPH_FWD);

  always_comb begin
    key_words_sel_o = KEY_WORDS_ZERO;
    round_key_sel_o = ROUND_KEY_DIRECT;

    case (phase_i)
      PH_INIT: begin
        // Forward starts from the first words, inverse from the last ones
        if (is_fwd || key_len_i == AES_128) begin
          key_words_sel_o = KEY_WORDS_0123;
        end else if (key_len_i == AES_192) begin
          key_words_sel_o = KEY_WORDS_2345;
        end else begin
          key_words_sel_o = KEY_WORDS_4567;
        end
      end

      PH_ROUND, PH_FINISH: begin
        // Inverse rounds always see the newest words in slots 0 to 3
        if (!is_fwd || key_len_i == AES_128) begin
          key_words_sel_o = KEY_WORDS_0123;
        end else if (key_len_i == AES_192) begin
          key_words_sel_o = KEY_WORDS_2345;
        end else begin
          key_words_sel_o = KEY_WORDS_4567;
        end

        // Equivalent inverse cipher needs InvMixColumns on the key
        if (phase_i == PH_ROUND && !is_fwd) begin
          round_key_sel_o = ROUND_KEY_MIXED;
        end
      end

      // No round key outside the cipher rounds
      default: key_words_sel_o = KEY_WORDS_ZERO;
    endcase
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cipher control testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  -f cipher_ctrl.f \
  --top-module cipher_ctrl_tb \
  -o cipher_ctrl_sim

./obj_dir/cipher_ctrl_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "NO ERRORS" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== tb/cipher_ctrl_tb.sv ====
/*
 * AES cipher control testbench
 * Stands in for the datapath, runs crypt, clear and error blocks
 * and checks the control outputs cycle by cycle
 */
`timescale 1ns/1ns
`default_nettype none

module cipher_ctrl_tb import cipher_ctrl_pkg::*; ();

  localparam int          SBOX_MIN   = 4;
  localparam int          NUM_CRYPT  = 30;
  localparam int          NUM_CLEAR  = 6;
  localparam int          NUM_ERROR  = 4;
  // 15 rounds of at most 12 cycles per block
  localparam int          TIMEOUT    = (NUM_CRYPT + NUM_CLEAR + NUM_ERROR) * 15 * 12 + 1000;
  localparam logic [31:0] SEED       = 32'he1e4;

  logic           clk_i;
  logic           rst_ni;
  logic           in_valid_i, crypt_i, key_clear_i, data_out_clear_i, out_ready_i;
  ciph_op_e       op_i;
  key_len_e       key_len_i;
  logic           sub_bytes_out_req_i, key_expand_out_req_i;
  logic           mux_sel_err_i, sp_enc_err_i, rnd_ctr_err_i, op_err_i, alert_fatal_i;
  logic           in_ready_o, out_valid_o, alert_o;
  state_sel_e     state_sel_o;
  logic           state_we_o, sub_bytes_en_o, sub_bytes_out_ack_o;
  add_rk_sel_e    add_rk_sel_o;
  key_full_sel_e  key_full_sel_o;
  key_dec_sel_e   key_dec_sel_o;
  logic           key_full_we_o, key_dec_we_o, key_expand_en_o;
  logic           key_expand_out_ack_o, key_expand_clear_o;
  rnd_ctr_t       rnd_ctr_o;
  key_words_sel_e key_words_sel_o;
  round_key_sel_e round_key_sel_o;

  // Random streams and result counters
  logic [31:0]    stim_rng;
  logic [31:0]    resp_rng;
  int             errors = 0;
  int             cycle = 0;

  // Monitor bookkeeping
  logic           busy_crypt, clr_active, clr_first, err_pending;
  logic           prev_en, prev_stall, prev_hs;
  logic           accept, hs, en;
  ciph_op_e       cmd_op;
  key_len_e       cmd_len;
  logic           cmd_key_clr, cmd_data_clr;
  key_full_sel_e  exp_full;
  round_phase_e   ph;
  int             ke_acks, exp_acks, step_start;

  cipher_ctrl_top #(
    .SBoxMinCycles (SBOX_MIN)
  ) DUT (
    .clk_i, .rst_ni, .in_valid_i, .in_ready_o, .out_valid_o, .out_ready_i,
    .crypt_i, .key_clear_i, .data_out_clear_i, .op_i, .key_len_i,
    .mux_sel_err_i, .sp_enc_err_i, .rnd_ctr_err_i, .op_err_i, .alert_fatal_i, .alert_o,
    .state_sel_o, .state_we_o, .add_rk_sel_o, .sub_bytes_en_o,
    .sub_bytes_out_req_i, .sub_bytes_out_ack_o,
    .key_full_sel_o, .key_full_we_o, .key_dec_sel_o, .key_dec_we_o, .key_expand_en_o,
    .key_expand_out_req_i, .key_expand_out_ack_o, .key_expand_clear_o,
    .rnd_ctr_o, .key_words_sel_o, .round_key_sel_o
  );

  ////////////////////////////////////////
  // Reference rules and helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic key_len_e pick_len(input logic [31:0] r);
    case (r % 32'd3)
      32'd0:   return AES_128;
      32'd1:   return AES_192;
      default: return AES_256;
    endcase
  endfunction

  function automatic rnd_ctr_t rounds_for(input key_len_e len);
    case (len)
      AES_192: return 4'd12;
      AES_256: return 4'd14;
      default: return 4'd10;
    endcase
  endfunction

  function automatic key_words_sel_e exp_words(input round_phase_e p, input ciph_op_e op,
                                               input key_len_e len);
    key_words_sel_e far;
    // Words at the far end of the key register
    case (len)
      AES_192: far = KEY_WORDS_2345;
      AES_256: far = KEY_WORDS_4567;
      default: far = KEY_WORDS_0123;
    endcase
    case (p)
      PH_INIT:             return (op == CIPH_INV) ? far : KEY_WORDS_0123;
      PH_ROUND, PH_FINISH: return (op == CIPH_FWD) ? far : KEY_WORDS_0123;
      default:             return KEY_WORDS_ZERO;
    endcase
  endfunction

  function automatic round_key_sel_e exp_round_key(input round_phase_e p, input ciph_op_e op);
    if (p == PH_ROUND && op == CIPH_INV) begin
      return ROUND_KEY_MIXED;
    end
    return ROUND_KEY_DIRECT;
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("error %s: got %h, expected %h", name, got, exp);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    errors++;
  endtask

  ////////////////////////////////////////
  // Clock and stimulus tasks
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  // Offer one command once the FSM is idle
  task automatic start_command(input logic crypt, input logic key_clr, input logic data_clr,
                               input ciph_op_e op, input key_len_e len);
    do @(posedge clk_i); while (!in_ready_o);
    in_valid_i       <= 1'b1;
    crypt_i          <= crypt;
    key_clear_i      <= key_clr;
    data_out_clear_i <= data_clr;
    op_i             <= op;
    key_len_i        <= len;
    @(posedge clk_i);
    // Op and key length stay put past acceptance
    in_valid_i       <= 1'b0;
    crypt_i          <= 1'b0;
    key_clear_i      <= 1'b0;
    data_out_clear_i <= 1'b0;
  endtask

  task automatic wait_output();
    do @(posedge clk_i); while (!(out_valid_o && out_ready_i));
  endtask

  task automatic run_error();
    int delay;
    stim_rng = xorshift32(stim_rng);
    delay    = int'(stim_rng % 32'd50);
    start_command(1'b1, 1'b0, 1'b0, stim_rng[8] ? CIPH_INV : CIPH_FWD, pick_len(stim_rng));
    repeat (delay) @(posedge clk_i);
    op_err_i <= 1'b1;
    @(posedge clk_i);
    op_err_i <= 1'b0;
    repeat (6) @(posedge clk_i);
    apply_reset();
  endtask

  initial begin
    int n;
    stim_rng         = xorshift32(SEED);
    rst_ni           <= 1'b0;
    in_valid_i       <= 1'b0;
    crypt_i          <= 1'b0;
    key_clear_i      <= 1'b0;
    data_out_clear_i <= 1'b0;
    op_i             <= CIPH_FWD;
    key_len_i        <= AES_128;
    mux_sel_err_i    <= 1'b0;
    sp_enc_err_i     <= 1'b0;
    rnd_ctr_err_i    <= 1'b0;
    op_err_i         <= 1'b0;
    alert_fatal_i    <= 1'b0;
    apply_reset();

    for (n = 0; n < NUM_CRYPT; n++) begin
      stim_rng = xorshift32(stim_rng);
      start_command(1'b1, 1'b0, 1'b0, stim_rng[8] ? CIPH_INV : CIPH_FWD,
                    pick_len(stim_rng));
      wait_output();
    end
    // Key only, data only, both; second pass also raises crypt
    for (n = 0; n < NUM_CLEAR; n++) begin
      start_command(n >= 3, (n % 3) != 1, (n % 3) != 0, CIPH_FWD, AES_128);
      wait_output();
    end
    for (n = 0; n < NUM_ERROR; n++) begin
      run_error();
    end

    repeat (5) @(posedge clk_i);
    $display("run done after %0d cycles with %0d errors", cycle, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  ////////////////////////////////////////
  // Datapath responders
  ////////////////////////////////////////

  initial begin
    logic [2:0] sb_wait;
    logic [2:0] ke_wait;
    resp_rng             = SEED;
    sb_wait              = 3'd0;
    ke_wait              = 3'd0;
    sub_bytes_out_req_i  <= 1'b0;
    key_expand_out_req_i <= 1'b0;
    out_ready_i          <= 1'b0;
    forever begin
      @(posedge clk_i);
      if (!rst_ni) begin
        sub_bytes_out_req_i  <= 1'b0;
        key_expand_out_req_i <= 1'b0;
        out_ready_i          <= 1'b0;
        sb_wait              = 3'd0;
        ke_wait              = 3'd0;
      end else begin
        // Roughly one stall cycle in four
        resp_rng    = xorshift32(resp_rng);
        out_ready_i <= (resp_rng[1:0] != 2'b00);
        // SubBytes result after a random delay
        if (sub_bytes_out_req_i) begin
          if (sub_bytes_out_ack_o) begin
            sub_bytes_out_req_i <= 1'b0;
            resp_rng = xorshift32(resp_rng);
            sb_wait  = resp_rng[2:0];
          end
        end else if (sub_bytes_en_o) begin
          if (sb_wait == 3'd0) begin
            sub_bytes_out_req_i <= 1'b1;
          end else begin
            sb_wait = sb_wait - 3'd1;
          end
        end
        // KeyExpand the same way
        if (key_expand_out_req_i) begin
          if (key_expand_out_ack_o) begin
            key_expand_out_req_i <= 1'b0;
            resp_rng = xorshift32(resp_rng);
            ke_wait  = resp_rng[2:0];
          end
        end else if (key_expand_en_o) begin
          if (ke_wait == 3'd0) begin
            key_expand_out_req_i <= 1'b1;
          end else begin
            ke_wait = ke_wait - 3'd1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // Monitor and checks
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle = cycle + 1;
    if (!rst_ni) begin
      busy_crypt  = 1'b0;
      clr_active  = 1'b0;
      clr_first   = 1'b0;
      err_pending = 1'b0;
      prev_en     = 1'b0;
      prev_stall  = 1'b0;
      prev_hs     = 1'b0;
      ke_acks     = 0;
      step_start  = 0;
    end else if (err_pending) begin
      // Terminal error until reset
      assert (alert_o) else report_value("alert_o", 32'(alert_o), 32'h1);
      assert (!in_ready_o) else report_value("in_ready_o", 32'(in_ready_o), 32'h0);
    end else if (!op_err_i) begin
      accept = in_valid_i && in_ready_o;
      hs     = out_valid_o && out_ready_i;
      en     = sub_bytes_en_o || key_expand_en_o;
      assert (!alert_o) else report_value("alert_o", 32'(alert_o), 32'h0);

      // Back-pressure
      if (prev_stall) begin
        assert (out_valid_o) else report_failure("out_valid_o dropped while out_ready_i was low");
      end
      if (out_valid_o && !out_ready_i) begin
        assert (!in_ready_o) else report_value("in_ready_o", 32'(in_ready_o), 32'h0);
      end
      if (prev_hs) begin
        assert (in_ready_o) else report_failure("in_ready_o did not return after the handshake");
      end

      // Step length seen by the S-Box gate
      if (en && !prev_en) begin
        step_start = cycle;
      end
      if (sub_bytes_out_ack_o || key_expand_out_ack_o) begin
        assert (cycle - step_start >= SBOX_MIN) else
          report_failure($sformatf("acknowledge came %0d cycles into a step, minimum is %0d",
                                   cycle - step_start, SBOX_MIN));
        step_start = cycle + 1;
      end

      // Phase from the add round key select and the enables
      ph = PH_OTHER;
      if (busy_crypt) begin
        if (key_expand_out_ack_o) begin
          ke_acks++;
        end
        if (add_rk_sel_o == ADD_RK_INIT) begin
          ph = PH_INIT;
        end else if (add_rk_sel_o == ADD_RK_FINAL) begin
          ph = PH_FINISH;
        end else if (sub_bytes_en_o) begin
          ph = PH_ROUND;
        end
      end
      assert (key_words_sel_o == exp_words(ph, cmd_op, cmd_len)) else
        report_value("key_words_sel_o", 32'(key_words_sel_o),
                     32'(exp_words(ph, cmd_op, cmd_len)));
      assert (round_key_sel_o == exp_round_key(ph, cmd_op)) else
        report_value("round_key_sel_o", 32'(round_key_sel_o), 32'(exp_round_key(ph, cmd_op)));

      // Round count at completion
      if (busy_crypt && out_valid_o) begin
        assert (rnd_ctr_o == rounds_for(cmd_len)) else
          report_value("rnd_ctr_o", 32'(rnd_ctr_o), 32'(rounds_for(cmd_len)));
        if (out_ready_i) begin
          exp_acks = int'(rounds_for(cmd_len));
          // AES-256 starts with two round keys
          if (cmd_len == AES_256) begin
            exp_acks = exp_acks - 1;
          end
          assert (ke_acks == exp_acks) else
            report_value("key_expand_out_ack_o count", 32'(ke_acks), 32'(exp_acks));
          busy_crypt = 1'b0;
        end
      end

      // Clear sequence
      if (clr_active) begin
        if (clr_first && cmd_data_clr) begin
          assert (state_we_o && state_sel_o == STATE_CLEAR) else
            report_failure("data clear did not write a cleared state first");
          assert (!out_valid_o) else report_value("out_valid_o", 32'(out_valid_o), 32'h0);
        end else begin
          assert (out_valid_o) else report_value("out_valid_o", 32'(out_valid_o), 32'h1);
          if (cmd_key_clr) begin
            assert (key_full_sel_o == KEY_FULL_CLEAR) else
              report_value("key_full_sel_o", 32'(key_full_sel_o), 32'(KEY_FULL_CLEAR));
            assert (key_dec_sel_o == KEY_DEC_CLEAR) else
              report_value("key_dec_sel_o", 32'(key_dec_sel_o), 32'(KEY_DEC_CLEAR));
            assert (key_full_we_o && key_dec_we_o) else
              report_failure("key clear did not write both key registers");
          end else begin
            assert (!key_full_we_o && !key_dec_we_o) else
              report_failure("key registers written without a key clear");
          end
          if (hs) begin
            clr_active = 1'b0;
          end
        end
        clr_first = 1'b0;
      end

      // Clear wins over crypt on a new command
      if (accept) begin
        cmd_op       = op_i;
        cmd_len      = key_len_i;
        cmd_key_clr  = key_clear_i;
        cmd_data_clr = data_out_clear_i;
        ke_acks      = 0;
        if (key_clear_i || data_out_clear_i) begin
          clr_active = 1'b1;
          clr_first  = 1'b1;
        end else if (crypt_i) begin
          exp_full = (op_i == CIPH_INV) ? KEY_FULL_DEC_INIT : KEY_FULL_ENC_INIT;
          assert (state_we_o && state_sel_o == STATE_INIT) else
            report_failure("crypt start did not load the input state");
          assert (key_full_sel_o == exp_full) else
            report_value("key_full_sel_o", 32'(key_full_sel_o), 32'(exp_full));
          assert (key_expand_clear_o) else
            report_value("key_expand_clear_o", 32'(key_expand_clear_o), 32'h1);
          busy_crypt = 1'b1;
        end
      end

      prev_en    = en;
      prev_stall = out_valid_o && !out_ready_i;
      prev_hs    = hs;
    end

    if (rst_ni && op_err_i) begin
      err_pending = 1'b1;
    end

    if (cycle > TIMEOUT) begin
      $display("timeout, run stopped after %0d cycles with %0d errors", cycle, errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

`default_nettype wire
